// ==== vec_alu_pkg.sv ====
`default_nettype none

package vec_alu_pkg;

	// Vector word size, lane 0 sits in the top bits
	localparam int VEC_W = 64;

	typedef logic [VEC_W-1:0] vec_word_t;

	// Instruction class, bits [0:5] of the instruction word
	typedef enum logic [5:0] {
		R_ALU     = 6'b101010,
		LOAD      = 6'b100000,
		STORE     = 6'b100001,
		BRANCH_EZ = 6'b100010,
		BRANCH_NZ = 6'b100011,
		NOP       = 6'b111100
	} op_code_e;

	// R-type function field
	// Shift, divide, modulo, square and root codes decode as illegal
	typedef enum logic [5:0] {
		VNOP   = 6'b000000,
		VAND   = 6'b000001,
		VOR    = 6'b000010,
		VXOR   = 6'b000011,
		VNOT   = 6'b000100,
		VMOV   = 6'b000101,
		VADD   = 6'b000110,
		VSUB   = 6'b000111,
		VMULEU = 6'b001000,
		VMULOU = 6'b001001,
		VSLL   = 6'b001010,
		VSRL   = 6'b001011,
		VSRA   = 6'b001100,
		VRTTH  = 6'b001101,
		VDIV   = 6'b001110,
		VMOD   = 6'b001111,
		VSQEU  = 6'b010000,
		VSQOU  = 6'b010001,
		VSQRT  = 6'b010010
	} r_func_e;

	// WW field
	typedef enum logic [1:0] {
		WIDTH_8  = 2'b00,
		WIDTH_16 = 2'b01,
		WIDTH_32 = 2'b10,
		WIDTH_64 = 2'b11
	} lane_width_e;

	// Instruction as seen by the ALU
	typedef struct packed {
		op_code_e    op_code;
		r_func_e     r_func;
		lane_width_e width;
		vec_word_t   operand_a;
		vec_word_t   operand_b;
	} alu_req_t;

	// Unit that owns the result
	typedef enum logic [1:0] {
		UNIT_NONE   = 2'd0,
		UNIT_LOGIC  = 2'd1,
		UNIT_ADDSUB = 2'd2,
		UNIT_MULT   = 2'd3
	} unit_sel_e;

	// Logic unit operations
	typedef enum logic [2:0] {
		LOP_AND  = 3'd0,
		LOP_OR   = 3'd1,
		LOP_XOR  = 3'd2,
		LOP_NOT  = 3'd3,
		LOP_MOV  = 3'd4,
		LOP_RTTH = 3'd5
	} logic_op_e;

	// Decoded controls
	typedef struct packed {
		unit_sel_e unit;
		logic_op_e logic_op;
		logic      subtract;
		logic      odd_lanes;
		logic      illegal;
	} alu_ctrl_t;

endpackage

`default_nettype wire

// ==== alu_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_decode (
	input  vec_alu_pkg::alu_req_t  req,
	output vec_alu_pkg::alu_ctrl_t ctrl
);

	import vec_alu_pkg::*;

	always_comb begin
		// Safe defaults, nothing owns the result
		ctrl.unit      = UNIT_NONE;
		ctrl.logic_op  = LOP_AND;
		ctrl.subtract  = 1'b0;
		ctrl.odd_lanes = 1'b0;
		ctrl.illegal   = 1'b1;

		// Only R-type instructions reach the units
		if (req.op_code == R_ALU) begin
			case (req.r_func)
				VAND: begin
					ctrl.unit     = UNIT_LOGIC;
					ctrl.logic_op = LOP_AND;
					ctrl.illegal  = 1'b0;
				end
				VOR: begin
					ctrl.unit     = UNIT_LOGIC;
					ctrl.logic_op = LOP_OR;
					ctrl.illegal  = 1'b0;
				end
				VXOR: begin
					ctrl.unit     = UNIT_LOGIC;
					ctrl.logic_op = LOP_XOR;
					ctrl.illegal  = 1'b0;
				end
				VNOT: begin
					ctrl.unit     = UNIT_LOGIC;
					ctrl.logic_op = LOP_NOT;
					ctrl.illegal  = 1'b0;
				end
				VMOV: begin
					ctrl.unit     = UNIT_LOGIC;
					ctrl.logic_op = LOP_MOV;
					ctrl.illegal  = 1'b0;
				end
				VRTTH: begin
					// Valid at every lane width
					ctrl.unit     = UNIT_LOGIC;
					ctrl.logic_op = LOP_RTTH;
					ctrl.illegal  = 1'b0;
				end
				VADD, VSUB: begin
					ctrl.unit     = UNIT_ADDSUB;
					ctrl.subtract = (req.r_func == VSUB);
					ctrl.illegal  = 1'b0;
				end
				VMULEU, VMULOU: begin
					// No 64x64 product fits a 64-bit word
					if (req.width != WIDTH_64) begin
						ctrl.unit      = UNIT_MULT;
						ctrl.odd_lanes = (req.r_func == VMULOU);
						ctrl.illegal   = 1'b0;
					end
				end
				// Reserved or removed functions
				VNOP, VSLL, VSRL, VSRA, VDIV, VMOD, VSQEU, VSQOU, VSQRT: begin
					ctrl.illegal = 1'b1;
				end
				default: begin
					ctrl.illegal = 1'b1;
				end
			endcase
		end
	end

	// Illegal requests never claim a unit
	always_comb begin
		assert (!(ctrl.illegal && (ctrl.unit != UNIT_NONE)))
			else $error("alu_decode: illegal request selects a unit");
	end

endmodule

`default_nettype wire

// ==== vec_logic_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module vec_logic_unit (
	input  vec_alu_pkg::logic_op_e   logic_op,
	input  vec_alu_pkg::lane_width_e width,
	input  vec_alu_pkg::vec_word_t   operand_a,
	input  vec_alu_pkg::vec_word_t   operand_b,
	output vec_alu_pkg::vec_word_t   logic_result
);

	import vec_alu_pkg::*;

	// Half-lane rotate of operand_a, one candidate per lane width
	// Index follows the WW encoding
	vec_word_t rot_by_width [4];

	for (genvar w = 0; w < 4; w++) begin : g_width
		localparam int LANE_W = 8 << w;
		localparam int HALF_W = LANE_W / 2;

		// Every lane is treated alike, so lane order does not matter here
		for (genvar i = 0; i < VEC_W / LANE_W; i++) begin : g_lane
			// Low half moves up, high half moves down
			assign rot_by_width[w][i*LANE_W +: LANE_W] = {
				operand_a[i*LANE_W +: HALF_W],
				operand_a[i*LANE_W + HALF_W +: HALF_W]
			};
		end
	end

	always_comb begin
		case (logic_op)
			LOP_AND:  logic_result = operand_a & operand_b;
			LOP_OR:   logic_result = operand_a | operand_b;
			LOP_XOR:  logic_result = operand_a ^ operand_b;
			// Unary ops use operand_a only
			LOP_NOT:  logic_result = ~operand_a;
			LOP_MOV:  logic_result = operand_a;
			LOP_RTTH: logic_result = rot_by_width[width];
			default:  logic_result = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== vec_add_sub.sv ====
`timescale 1ns/1ps
`default_nettype none

module vec_add_sub (
	input  logic                     subtract,
	input  vec_alu_pkg::lane_width_e width,
	input  vec_alu_pkg::vec_word_t   operand_a,
	input  vec_alu_pkg::vec_word_t   operand_b,
	output vec_alu_pkg::vec_word_t   sum_result
);

	import vec_alu_pkg::*;

	localparam int NUM_BYTES = VEC_W / 8;

	// Byte b is the lowest byte of a lane, byte 0 is the word LSB
	logic [NUM_BYTES-1:0] lane_start;

	// Carry into byte b from byte b-1
	logic [NUM_BYTES-1:0] carry;

	// Two's complement operand for subtract
	vec_word_t b_eff;

	always_comb begin
		case (width)
			WIDTH_8:  lane_start = 8'hff;
			WIDTH_16: lane_start = 8'h55;
			WIDTH_32: lane_start = 8'h11;
			default:  lane_start = 8'h01;
		endcase
	end

	assign b_eff = subtract ? ~operand_b : operand_b;

	// Nothing enters below the lowest byte
	assign carry[0] = 1'b0;

	for (genvar b = 0; b < NUM_BYTES; b++) begin : g_slice
		logic slice_cin;

		// Lane edge blocks the chain and takes the +1 of subtract instead
		assign slice_cin = lane_start[b] ? subtract : carry[b];

		if (b < NUM_BYTES - 1) begin : g_chain
			assign {carry[b+1], sum_result[b*8 +: 8]} =
				{1'b0, operand_a[b*8 +: 8]} + {1'b0, b_eff[b*8 +: 8]} + 9'(slice_cin);
		end else begin : g_top
			// Carry out of the word is dropped
			assign sum_result[b*8 +: 8] =
				operand_a[b*8 +: 8] + b_eff[b*8 +: 8] + 8'(slice_cin);
		end
	end

endmodule

`default_nettype wire

// ==== vec_mult_eo.sv ====
`timescale 1ns/1ps
`default_nettype none

module vec_mult_eo (
	input  logic                     odd_lanes,
	input  vec_alu_pkg::lane_width_e width,
	input  vec_alu_pkg::vec_word_t   operand_a,
	input  vec_alu_pkg::vec_word_t   operand_b,
	output vec_alu_pkg::vec_word_t   product_result
);

	import vec_alu_pkg::*;

	// Product word per source width: 8, 16, 32
	vec_word_t prod_by_width [3];

	for (genvar w = 0; w < 3; w++) begin : g_width
		localparam int LANE_W = 8 << w;
		localparam int PROD_W = 2 * LANE_W;

		for (genvar j = 0; j < VEC_W / PROD_W; j++) begin : g_pair
			// Top bit of source lane 2j, also top bit of product lane j
			localparam int TOP = VEC_W - 1 - j * PROD_W;

			logic [LANE_W-1:0] a_lane;
			logic [LANE_W-1:0] b_lane;

			// Odd lane 2j+1 sits just below even lane 2j
			assign a_lane = odd_lanes ? operand_a[TOP - LANE_W -: LANE_W]
				: operand_a[TOP -: LANE_W];
			assign b_lane = odd_lanes ? operand_b[TOP - LANE_W -: LANE_W]
				: operand_b[TOP -: LANE_W];

			// Unsigned, full double-width product
			assign prod_by_width[w][TOP -: PROD_W] = PROD_W'(a_lane) * PROD_W'(b_lane);
		end
	end

	always_comb begin
		case (width)
			WIDTH_8:  product_result = prod_by_width[0];
			WIDTH_16: product_result = prod_by_width[1];
			WIDTH_32: product_result = prod_by_width[2];
			// 64-bit lanes are rejected in decode
			default:  product_result = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== alu_result_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_result_stage (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   op_valid,
	input  vec_alu_pkg::alu_ctrl_t ctrl,
	input  vec_alu_pkg::vec_word_t logic_result,
	input  vec_alu_pkg::vec_word_t sum_result,
	input  vec_alu_pkg::vec_word_t product_result,
	output vec_alu_pkg::vec_word_t result,
	output logic                   result_valid,
	output logic                   illegal_op
);

	import vec_alu_pkg::*;

	// Result of the owning unit
	vec_word_t selected;

	always_comb begin
		case (ctrl.unit)
			UNIT_LOGIC:  selected = logic_result;
			UNIT_ADDSUB: selected = sum_result;
			UNIT_MULT:   selected = product_result;
			// Illegal ops return zero
			default:     selected = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			result       <= '0;
			result_valid <= 1'b0;
			illegal_op   <= 1'b0;
		end else begin
			result_valid <= op_valid;
			// Flag lives only in the strobe cycle
			illegal_op   <= op_valid & ctrl.illegal;
			// Result holds through idle cycles
			if (op_valid) begin
				result <= selected;
			end
		end
	end

	// Illegal flag only comes with a valid zero result
	assert property (@(posedge clk) disable iff (reset)
		illegal_op |-> (result_valid && (result == '0)))
		else $error("alu_result_stage: illegal_op without a valid zero result");

endmodule

`default_nettype wire

// ==== vec_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module vec_alu (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   op_valid,
	input  vec_alu_pkg::alu_req_t  req,
	output vec_alu_pkg::vec_word_t result,
	output logic                   result_valid,
	output logic                   illegal_op
);

	import vec_alu_pkg::*;

	alu_ctrl_t ctrl;

	// Unit outputs, all combinational
	vec_word_t logic_result;
	vec_word_t sum_result;
	vec_word_t product_result;

	alu_decode u_decode (
		.req  (req),
		.ctrl (ctrl)
	);

	vec_logic_unit u_logic (
		.logic_op     (ctrl.logic_op),
		.width        (req.width),
		.operand_a    (req.operand_a),
		.operand_b    (req.operand_b),
		.logic_result (logic_result)
	);

	vec_add_sub u_add_sub (
		.subtract   (ctrl.subtract),
		.width      (req.width),
		.operand_a  (req.operand_a),
		.operand_b  (req.operand_b),
		.sum_result (sum_result)
	);

	vec_mult_eo u_mult (
		.odd_lanes      (ctrl.odd_lanes),
		.width          (req.width),
		.operand_a      (req.operand_a),
		.operand_b      (req.operand_b),
		.product_result (product_result)
	);

	// Single register stage
	alu_result_stage u_result (
		.clk            (clk),
		.reset          (reset),
		.op_valid       (op_valid),
		.ctrl           (ctrl),
		.logic_result   (logic_result),
		.sum_result     (sum_result),
		.product_result (product_result),
		.result         (result),
		.result_valid   (result_valid),
		.illegal_op     (illegal_op)
	);

	// Multiplier never owns a request with 64-bit lanes
	assert property (@(posedge clk) disable iff (reset)
		(op_valid && (ctrl.unit == UNIT_MULT)) |-> (req.width != WIDTH_64))
		else $error("vec_alu: multiplier selected at width 64");

endmodule

`default_nettype wire

// ==== tb_vec_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_vec_alu;

	import vec_alu_pkg::*;

	localparam logic [31:0] SEED = 32'h088fbb92;

	// One stimulus line with request and expected outputs
	typedef struct packed {
		alu_req_t  req;
		vec_word_t result;
		logic      illegal;
	} stim_t;

	logic      clk;
	logic      reset;
	logic      op_valid;
	alu_req_t  req;
	vec_word_t result;
	logic      result_valid;
	logic      illegal_op;

	stim_t     stim_q[$];
	// Indexes of issued lines in issue order
	int        pending_q[$];
	// Value result must keep while idle
	vec_word_t held_result = '0;
	int        cycle_count = 0;
	int        cycle_limit = 0;

	vec_alu u_vec_alu (
		.clk          (clk),
		.reset        (reset),
		.op_valid     (op_valid),
		.req          (req),
		.result       (result),
		.result_valid (result_valid),
		.illegal_op   (illegal_op)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_result(
		input vec_word_t got,
		input vec_word_t exp,
		input string     what
	);
		if (got !== exp) begin
			abort_run($sformatf("ERROR at %0t: %s result %h, expected %h",
				$time, what, got, exp));
		end
	endtask

	task automatic check_illegal(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			abort_run($sformatf("ERROR at %0t: %s illegal_op %b, expected %b",
				$time, what, got, exp));
		end
	endtask

	// Outputs settle half a cycle after the edge that set them
	task automatic check_outputs();
		int idx;
		// op_valid still holds the value sampled at the last rising edge
		if (result_valid !== op_valid) begin
			abort_run($sformatf("ERROR at %0t: result_valid %b one cycle after op_valid %b",
				$time, result_valid, op_valid));
		end
		if (result_valid === 1'b1) begin
			if (pending_q.size() == 0) begin
				abort_run("result_valid went high with no instruction outstanding");
			end else begin
				idx = pending_q.pop_front();
				check_result(result, stim_q[idx].result, $sformatf("line %0d", idx));
				check_illegal(illegal_op, stim_q[idx].illegal, $sformatf("line %0d", idx));
				held_result = stim_q[idx].result;
			end
		end else begin
			// Idle cycle keeps the flag low and the result unchanged
			check_illegal(illegal_op, 1'b0, "idle cycle");
			check_result(result, held_result, "idle cycle");
		end
	endtask

	task automatic tick();
		@(negedge clk);
		check_outputs();
	endtask

	task automatic load_stimulus();
		int         fd;
		int         count;
		string      line;
		logic [5:0] op;
		logic [5:0] fn;
		logic [1:0] ww;
		vec_word_t  a;
		vec_word_t  b;
		vec_word_t  exp_result;
		logic       exp_illegal;
		stim_t      entry;
		fd = $fopen("vec_alu_stimulus.txt", "r");
		if (fd == 0) begin
			abort_run("Could not open vec_alu_stimulus.txt");
		end else begin
			while (!$feof(fd)) begin
				count = $fgets(line, fd);
				// Blank and comment lines skipped
				if (count > 1 && line.getc(0) != "#") begin
					count = $sscanf(line, "%h %h %h %h %h %h %h",
						op, fn, ww, a, b, exp_result, exp_illegal);
					if (count != 7) begin
						abort_run($sformatf("Malformed stimulus line: %s", line));
					end
					entry.req.op_code   = op_code_e'(op);
					entry.req.r_func    = r_func_e'(fn);
					entry.req.width     = lane_width_e'(ww);
					entry.req.operand_a = a;
					entry.req.operand_b = b;
					entry.result        = exp_result;
					entry.illegal       = exp_illegal;
					stim_q.push_back(entry);
				end
			end
			$fclose(fd);
		end
	endtask

	// Watchdog armed once the stimulus is known
	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_limit != 0 && cycle_count > cycle_limit) begin
			abort_run($sformatf("Timeout after %0d cycles, results never arrived",
				cycle_count));
		end
	end

	initial begin
		int idle;
		void'($urandom(SEED));
		reset    = 1'b1;
		op_valid = 1'b0;
		req      = '0;
		load_stimulus();
		if (stim_q.size() == 0) begin
			abort_run("Stimulus file holds no instructions");
		end
		cycle_limit = 16 + 4 * stim_q.size() + 20;

		repeat (16) tick();
		reset = 1'b0;
		// Quiet cycles right after reset
		repeat (2) tick();

		foreach (stim_q[i]) begin
			// Zero idle cycles give back-to-back issue
			idle = $urandom % 3;
			repeat (idle) begin
				tick();
				op_valid = 1'b0;
				req      = '0;
			end
			tick();
			op_valid = 1'b1;
			req      = stim_q[i].req;
			pending_q.push_back(i);
		end
		tick();
		op_valid = 1'b0;
		req      = '0;
		// Drain the last result
		repeat (2) tick();

		if (pending_q.size() != 0) begin
			abort_run("Results still outstanding at the end of the run");
		end else begin
			$display("Simulation completed successfully");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== vec_alu_stimulus.txt ====
# op_code r_func width operand_a operand_b expected_result expected_illegal
# all hex, width is the WW code (0=8, 1=16, 2=32, 3=64)
# bitwise and move
2a 01 3 0123456789abcdef ff00f0f0aaaa5555 0100406088aa4545 0
2a 02 3 0123456789abcdef ff00f0f0aaaa5555 ff23f5f7ababddff 0
2a 03 0 0123456789abcdef ff00f0f0aaaa5555 fe23b597230198ba 0
2a 04 1 0123456789abcdef ff00f0f0aaaa5555 fedcba9876543210 0
2a 05 2 0123456789abcdef ff00f0f0aaaa5555 0123456789abcdef 0
# rotate by half lane
2a 0d 0 0123456789abcdef 0000000000000000 1032547698badcfe 0
2a 0d 1 0123456789abcdef 0000000000000000 23016745ab89efcd 0
2a 0d 2 0123456789abcdef 0000000000000000 45670123cdef89ab 0
2a 0d 3 0123456789abcdef 0000000000000000 89abcdef01234567 0
# add, no carry across lanes
2a 06 0 ff7f80ff0001fe10 0101800101ff0220 0080000001000030 0
2a 06 1 ffff00017fffff00 0001ffff00010100 0000000080000000 0
2a 06 2 ffffffff12345678 0000000187654321 0000000099999999 0
2a 06 3 00000000ffffffff 0000000000000001 0000000100000000 0
# subtract, no borrow across lanes
2a 07 0 0010ff8000017f05 0101ff0101020103 ff0f007fffff7e02 0
2a 07 1 0000100080000005 0001000100010003 ffff0fff7fff0002 0
2a 07 2 0000000012345678 0000000102030405 ffffffff10315273 0
2a 07 3 0000000100000000 0000000000000001 00000000ffffffff 0
# even and odd widening multiply
2a 08 0 0123456789abcdef 02030405ff10ff02 000201148877cc33 0
2a 09 0 0123456789abcdef 02030405ff10ff02 006902030ab001de 0
2a 08 1 ffff000212340010 ffff000300100100 fffe000100012340 0
2a 09 1 ffff000212340010 ffff000300100100 0000000600001000 0
2a 08 2 ffffffff00000003 ffffffff00000005 fffffffe00000001 0
2a 09 2 ffffffff00000003 ffffffff00000005 000000000000000f 0
# illegal: multiply at 64, VDIV, VNOP, LOAD
2a 08 3 0123456789abcdef fedcba9876543210 0000000000000000 1
2a 0e 0 0123456789abcdef fedcba9876543210 0000000000000000 1
2a 00 0 0123456789abcdef fedcba9876543210 0000000000000000 1
20 06 0 0123456789abcdef fedcba9876543210 0000000000000000 1

// ==== sim.f ====
vec_alu_pkg.sv
alu_decode.sv
vec_logic_unit.sv
vec_add_sub.sv
vec_mult_eo.sv
alu_result_stage.sv
vec_alu.sv
tb_vec_alu.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator and run from the project root
# The run passes only when the pass message shows up in the output
verilator --binary --timing --assert -f sim.f --top-module tb_vec_alu -o tb_vec_alu \
	&& ./obj_dir/tb_vec_alu | tee /dev/stderr | grep "Simulation completed successfully" > /dev/null \
	&& echo "RESULT: PASS" \
	|| { echo "RESULT: FAIL"; exit 1; }
